// ==== board_pkg.sv ====
// Shared definitions of the simulation board adapter.
// Pin counts, CHERI fault kinds and the packed pad groups that travel
// between the system side, the pad ring and the device models.

`default_nettype none

package board_pkg;

  // Number of open-drain I2C buses that get resolved.
  // HAT ID, HAT secondary and QWIIC1, in that order.
  localparam int unsigned NumI2cBuses = 3;

  // Number of CHERI fault kinds reported by the system.
  localparam int unsigned NumFaults = 9;

  // Number of loopback pin pairs retimed by the pad ring.
  localparam int unsigned NumLoopback = 7;

  // Width of a fault code.
  localparam int unsigned FaultW = 4;

  // CHERI fault kinds.
  // Codes follow the bit order of the fault vector.
  typedef enum logic [FaultW-1:0] {
    FaultBounds              = 4'd0,
    FaultTag                 = 4'd1,
    FaultSeal                = 4'd2,
    FaultPermitExecute       = 4'd3,
    FaultPermitLoad          = 4'd4,
    FaultPermitStore         = 4'd5,
    FaultPermitStoreCap      = 4'd6,
    FaultPermitStoreLocalCap = 4'd7,
    FaultPermitAccSysRegs    = 4'd8
  } fault_e;

  // Controller side of one I2C bus.
  // Each line has a value and an output enable.
  typedef struct packed {
    logic scl;
    logic scl_oe;
    logic sda;
    logic sda_oe;
  } i2c_ctrl_t;

  // One I2C line pair.
  // Used for device pull-downs and for the resolved bus.
  typedef struct packed {
    logic scl;
    logic sda;
  } i2c_line_t;

  // Controller side of the PMOD SPI flash port.
  typedef struct packed {
    logic cs;
    logic cs_oe;
    logic sck;
    logic sck_oe;
    logic copi;
    logic copi_oe;
  } spi_ctrl_t;

  // PMOD SPI lines toward the flash model.
  // Undriven lines idle high.
  typedef struct packed {
    logic cs;
    logic sck;
    logic copi;
  } spi_line_t;

  // RS485 transceiver controls from the system.
  typedef struct packed {
    logic di;   // Transmit data.
    logic de;   // Driver enable, active high.
    logic ren;  // Receiver enable, active low.
  } rs485_ctrl_t;

  // Loopback pins, one bit per pin pair.
  typedef logic [NumLoopback-1:0] loop_t;

endpackage

`default_nettype wire

// ==== pad_ring.sv ====
// Pad ring of the simulation board adapter.
// Resolves open-drain I2C, idle-high SPI and half-duplex RS485 pads,
// and retimes the loopback pins through a single register stage.

`timescale 1ns/10ps
`default_nettype none

module pad_ring import board_pkg::*; (
  input  logic                        clk_i,

  // I2C buses.
  // Controller side, device pull-downs and the resolved lines.
  input  i2c_ctrl_t [NumI2cBuses-1:0] i2c_ctrl_i,
  input  i2c_line_t [NumI2cBuses-1:0] i2c_dev_i,
  output i2c_line_t [NumI2cBuses-1:0] i2c_bus_o,

  // PMOD SPI flash port.
  input  spi_ctrl_t                   spi_ctrl_i,
  output spi_line_t                   spi_line_o,

  // RS485 transceiver and serial model.
  input  rs485_ctrl_t                 rs485_ctrl_i,
  input  logic                        rs485_model_tx_i,
  output logic                        rs485_rx_o,
  output logic                        rs485_model_rx_o,

  // Loopback pins.
  input  loop_t                       loop_i,
  output loop_t                       loop_o
);

  // Pad output with an enable.
  // A disabled pad is pulled up and reads as 1.
  function automatic logic idle_high(input logic val, input logic oe);
    return oe ? val : 1'b1;
  endfunction

  // Controller drive of each I2C bus after the pull-up.
  i2c_line_t [NumI2cBuses-1:0] i2c_drv;

  // Loopback retiming register.
  loop_t loop_q;

  // I2C open-drain resolution.
  for (genvar b = 0; b < NumI2cBuses; b++) begin : gen_i2c
    assign i2c_drv[b].scl = idle_high(i2c_ctrl_i[b].scl, i2c_ctrl_i[b].scl_oe);
    assign i2c_drv[b].sda = idle_high(i2c_ctrl_i[b].sda, i2c_ctrl_i[b].sda_oe);

    // Wired-AND of controller and device.
    // Both sides see the same line, so no false contention.
    assign i2c_bus_o[b].scl = i2c_drv[b].scl & i2c_dev_i[b].scl;
    assign i2c_bus_o[b].sda = i2c_drv[b].sda & i2c_dev_i[b].sda;

    // A controller that pulls a line low must always win on the bus.
    a_i2c_ctrl_low_wins : assert property (@(posedge clk_i)
      !(i2c_ctrl_i[b].scl_oe && !i2c_ctrl_i[b].scl && i2c_bus_o[b].scl) &&
      !(i2c_ctrl_i[b].sda_oe && !i2c_ctrl_i[b].sda && i2c_bus_o[b].sda))
      else $error("I2C bus %0d high while its controller drives low", b);
  end

  // SPI flash lines idle high when not driven.
  assign spi_line_o.cs   = idle_high(spi_ctrl_i.cs, spi_ctrl_i.cs_oe);
  assign spi_line_o.sck  = idle_high(spi_ctrl_i.sck, spi_ctrl_i.sck_oe);
  assign spi_line_o.copi = idle_high(spi_ctrl_i.copi, spi_ctrl_i.copi_oe);

  // RS485 half-duplex gating.
  // Receiver is blocked while ren is high.
  assign rs485_rx_o = rs485_ctrl_i.ren ? 1'b0 : rs485_model_tx_i;

  // Line idles high unless the driver is enabled.
  assign rs485_model_rx_o = rs485_ctrl_i.de ? rs485_ctrl_i.di : 1'b1;

  // Loopback pins pass through one register stage.
  // This breaks the combinational loop through the pin map.
  always_ff @(posedge clk_i) begin
    loop_q <= loop_i;
  end

  assign loop_o = loop_q;

endmodule

`default_nettype wire

// ==== fault_reporter.sv ====
// CHERI fault reporter.
// Keeps a sticky record of each fault kind and reports every first
// occurrence, lowest index first, over a four-phase req/ack handshake.

`timescale 1ns/10ps
`default_nettype none

module fault_reporter import board_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Fault bits from the system, modulated like LED drives.
  input  logic [NumFaults-1:0] fault_i,
  output logic [NumFaults-1:0] faults_seen_o,

  // Four-phase report handshake.
  output logic                 report_req_o,
  input  logic                 report_ack_i,
  output fault_e               report_code_o
);

  // Handshake states.
  typedef enum logic [1:0] {
    Idle,
    Req,
    WaitAckLow
  } state_e;

  state_e state_q, state_d;

  // Recorded and already reported fault kinds.
  logic [NumFaults-1:0] seen_q;
  logic [NumFaults-1:0] reported_q;
  logic [NumFaults-1:0] pending;

  // Code on the wire and the next one to send.
  fault_e code_q;
  fault_e next_code;

  // A new report starts this cycle.
  logic launch;

  // Recorded but not yet reported.
  assign pending = seen_q & ~reported_q;

  // Lowest pending index wins.
  // Scan downwards so the last hit is the lowest.
  always_comb begin
    next_code = FaultBounds;
    for (int i = NumFaults - 1; i >= 0; i--) begin
      if (pending[i]) begin
        next_code = fault_e'(FaultW'(i));
      end
    end
  end

  // Start only from idle, with ack already low.
  assign launch = (state_q == Idle) && (|pending) && !report_ack_i;

  // Handshake FSM.
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (launch) begin
          state_d = Req;
        end
      end
      Req: begin
        // Ack seen, drop req.
        if (report_ack_i) begin
          state_d = WaitAckLow;
        end
      end
      WaitAckLow: begin
        // Outside must release ack before the next req.
        if (!report_ack_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      seen_q     <= '0;
      reported_q <= '0;
    end else begin
      state_q <= state_d;
      // Sticky record, also under back-pressure.
      seen_q  <= seen_q | fault_i;
      // Mark as reported when its request goes out.
      if (launch) begin
        reported_q[next_code] <= 1'b1;
      end
    end
  end

  // Code register, loaded once per report.
  always_ff @(posedge clk_i) begin
    if (launch) begin
      code_q <= next_code;
    end
  end

  assign faults_seen_o = seen_q;
  assign report_req_o  = (state_q == Req);
  assign report_code_o = code_q;

  // Req holds until the outside acknowledges.
  a_req_until_ack : assert property (@(posedge clk_i) disable iff (!rst_ni)
    report_req_o && !report_ack_i |=> report_req_o)
    else $error("Report req dropped before ack");

  // Code stays put for the whole request.
  a_code_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    report_req_o |=> !report_req_o || $stable(report_code_o))
    else $error("Report code changed while req high");

  // No new request while the previous ack is still up.
  a_no_req_on_ack : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !report_req_o && report_ack_i |=> !report_req_o)
    else $error("Report req rose while ack high");

endmodule

`default_nettype wire

// ==== sim_board_top.sv ====
// Simulation board adapter top level.
// Joins the pad ring and the CHERI fault reporter between the
// system pins and the virtual peripheral models.

`timescale 1ns/10ps
`default_nettype none

module sim_board_top import board_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // I2C buses.
  input  i2c_ctrl_t [NumI2cBuses-1:0] i2c_ctrl_i,
  input  i2c_line_t [NumI2cBuses-1:0] i2c_dev_i,
  output i2c_line_t [NumI2cBuses-1:0] i2c_bus_o,

  // PMOD SPI flash, CIPO goes straight back to the system.
  input  spi_ctrl_t                   spi_ctrl_i,
  output spi_line_t                   spi_line_o,
  input  logic                        spi_cipo_i,
  output logic                        spi_cipo_o,

  // RS485.
  input  rs485_ctrl_t                 rs485_ctrl_i,
  input  logic                        rs485_model_tx_i,
  output logic                        rs485_rx_o,
  output logic                        rs485_model_rx_o,

  // Loopback pins.
  input  loop_t                       loop_i,
  output loop_t                       loop_o,

  // CHERI faults and their report handshake.
  input  logic [NumFaults-1:0]        fault_i,
  output logic [NumFaults-1:0]        faults_seen_o,
  output logic                        report_req_o,
  input  logic                        report_ack_i,
  output fault_e                      report_code_o
);

  // Flash CIPO needs no pad logic.
  assign spi_cipo_o = spi_cipo_i;

  pad_ring u_pad_ring (
    .clk_i            (clk_i),
    .i2c_ctrl_i       (i2c_ctrl_i),
    .i2c_dev_i        (i2c_dev_i),
    .i2c_bus_o        (i2c_bus_o),
    .spi_ctrl_i       (spi_ctrl_i),
    .spi_line_o       (spi_line_o),
    .rs485_ctrl_i     (rs485_ctrl_i),
    .rs485_model_tx_i (rs485_model_tx_i),
    .rs485_rx_o       (rs485_rx_o),
    .rs485_model_rx_o (rs485_model_rx_o),
    .loop_i           (loop_i),
    .loop_o           (loop_o)
  );

  fault_reporter u_fault_reporter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fault_i       (fault_i),
    .faults_seen_o (faults_seen_o),
    .report_req_o  (report_req_o),
    .report_ack_i  (report_ack_i),
    .report_code_o (report_code_o)
  );

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
// Testbench clock and reset generator.
// 10 ns clock, active-low reset held for the first three cycles.

`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  localparam time ClkPeriod = 10ns;
  localparam int  ResetCycles = 3;

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  // Release lands on a falling edge, away from the sampling edge.
  initial begin
    rst_no = 1'b0;
    #(ResetCycles * ClkPeriod);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_sim_board.sv ====
// Testbench of the simulation board adapter.
// Random pad traffic, scheduled CHERI fault pulses and a slow ack
// responder, checked by concurrent assertions against reference models.

`timescale 1ns/10ps
`default_nettype none

module tb_sim_board import board_pkg::*; ();

  localparam int  NumCycles   = 200;
  localparam int  SlowAckFrom = 100;
  localparam int  DrainMargin = 400;
  localparam time WatchdogNs  = (NumCycles + DrainMargin) * 10ns;

  logic clk;
  logic rst_n;

  // DUT stimulus.
  i2c_ctrl_t [NumI2cBuses-1:0] i2c_ctrl;
  i2c_line_t [NumI2cBuses-1:0] i2c_dev;
  spi_ctrl_t            spi_ctrl;
  logic                 spi_cipo;
  rs485_ctrl_t          rs485_ctrl;
  logic                 rs485_model_tx;
  loop_t                loop_in;
  logic [NumFaults-1:0] fault;
  logic                 report_ack;

  // DUT responses.
  i2c_line_t [NumI2cBuses-1:0] i2c_bus;
  spi_line_t            spi_line;
  logic                 spi_cipo_out;
  logic                 rs485_rx;
  logic                 rs485_model_rx;
  loop_t                loop_out;
  logic [NumFaults-1:0] faults_seen;
  logic                 report_req;
  fault_e               report_code;

  // Reference state, one edge behind where needed.
  logic [NumFaults-1:0] seen_m;
  logic [NumFaults-1:0] reported_m;
  logic [NumFaults-1:0] pending_prev;
  logic                 req_prev;
  fault_e               code_prev;
  loop_t                loop_prev;

  int   errors;
  int   reports;
  int   seed;
  logic ack_slow;

  tb_clkgen u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  sim_board_top dut0 (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .i2c_ctrl_i       (i2c_ctrl),
    .i2c_dev_i        (i2c_dev),
    .i2c_bus_o        (i2c_bus),
    .spi_ctrl_i       (spi_ctrl),
    .spi_line_o       (spi_line),
    .spi_cipo_i       (spi_cipo),
    .spi_cipo_o       (spi_cipo_out),
    .rs485_ctrl_i     (rs485_ctrl),
    .rs485_model_tx_i (rs485_model_tx),
    .rs485_rx_o       (rs485_rx),
    .rs485_model_rx_o (rs485_model_rx),
    .loop_i           (loop_in),
    .loop_o           (loop_out),
    .fault_i          (fault),
    .faults_seen_o    (faults_seen),
    .report_req_o     (report_req),
    .report_ack_i     (report_ack),
    .report_code_o    (report_code)
  );

  // Line is low if the controller pulls it low or the device does.
  function automatic logic resolve_open_drain(input logic val, input logic oe, input logic dev);
    return !(oe && !val) && dev;
  endfunction

  // A released pad floats up to 1.
  function automatic logic pulled_up_level(input logic val, input logic oe);
    return val || !oe;
  endfunction

  function automatic spi_line_t expect_spi(input spi_ctrl_t c);
    spi_line_t l;
    l.cs   = pulled_up_level(c.cs, c.cs_oe);
    l.sck  = pulled_up_level(c.sck, c.sck_oe);
    l.copi = pulled_up_level(c.copi, c.copi_oe);
    return l;
  endfunction

  // Index of the lowest set bit, 4'hf when none.
  function automatic logic [3:0] lowest_set(input logic [NumFaults-1:0] mask);
    logic [3:0] idx;
    idx = 4'hf;
    for (int i = 0; i < NumFaults; i++) begin
      if (mask[i] && idx == 4'hf) idx = 4'(i);
    end
    return idx;
  endfunction

  function automatic logic [NumFaults-1:0] fault_bit(input fault_e f);
    return NumFaults'(1) << f;
  endfunction

  // Fault pulses per stimulus cycle; later ones overlap slow acks.
  function automatic logic [NumFaults-1:0] fault_pattern(input int cyc);
    case (cyc)
      10, 11: return fault_bit(FaultSeal) | fault_bit(FaultPermitLoad);
      20:     return fault_bit(FaultBounds) | fault_bit(FaultTag);
      30:     return fault_bit(FaultSeal);
      40:     return fault_bit(FaultBounds);
      120:    return fault_bit(FaultPermitStore) | fault_bit(FaultPermitAccSysRegs);
      125:    return fault_bit(FaultPermitStoreCap);
      128:    return fault_bit(FaultPermitExecute);
      130:    return fault_bit(FaultPermitStoreLocalCap) | fault_bit(FaultTag);
      140:    return '1;
      default: return '0;
    endcase
  endfunction

  task automatic drive_pads();
    logic [31:0] rnd;
    rnd = $random(seed);
    // Twelve controller bits, then six device bits.
    i2c_ctrl = rnd[11:0];
    i2c_dev  = rnd[17:12];
    spi_ctrl = rnd[23:18];
    spi_cipo = rnd[24];
    rs485_ctrl     = rnd[27:25];
    rs485_model_tx = rnd[28];
    rnd = $random(seed);
    loop_in = rnd[NumLoopback-1:0];
  endtask

  // Reference model of the fault record and the reports seen.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_m       <= '0;
      reported_m   <= '0;
      pending_prev <= '0;
      req_prev     <= 1'b0;
      reports      <= 0;
    end else begin
      seen_m       <= seen_m | fault;
      pending_prev <= seen_m & ~reported_m;
      req_prev     <= report_req;
      if (report_req && !req_prev) begin
        reported_m[report_code] <= 1'b1;
        reports <= reports + 1;
      end
    end
  end

  always @(posedge clk) begin
    code_prev <= report_code;
    loop_prev <= loop_in;
  end

  for (genvar b = 0; b < NumI2cBuses; b++) begin : gen_i2c_chk
    a_i2c_scl : assert property (@(posedge clk) i2c_bus[b].scl ==
      resolve_open_drain(i2c_ctrl[b].scl, i2c_ctrl[b].scl_oe, i2c_dev[b].scl))
      else begin
        errors++;
        $display("Mismatch i2c_bus_o[%0d].scl: got %h, ctrl %h dev %h", b,
                 $sampled(i2c_bus[b].scl), $sampled(i2c_ctrl[b]), $sampled(i2c_dev[b]));
      end
    a_i2c_sda : assert property (@(posedge clk) i2c_bus[b].sda ==
      resolve_open_drain(i2c_ctrl[b].sda, i2c_ctrl[b].sda_oe, i2c_dev[b].sda))
      else begin
        errors++;
        $display("Mismatch i2c_bus_o[%0d].sda: got %h, ctrl %h dev %h", b,
                 $sampled(i2c_bus[b].sda), $sampled(i2c_ctrl[b]), $sampled(i2c_dev[b]));
      end
  end

  a_spi : assert property (@(posedge clk) spi_line == expect_spi(spi_ctrl))
    else begin
      errors++;
      $display("Mismatch spi_line_o: got %h expected %h",
               $sampled(spi_line), expect_spi($sampled(spi_ctrl)));
    end

  a_cipo : assert property (@(posedge clk) spi_cipo_out == spi_cipo)
    else begin
      errors++;
      $display("Mismatch spi_cipo_o: got %h expected %h", $sampled(spi_cipo_out),
               $sampled(spi_cipo));
    end

  // Receiver blocked while ren is high.
  a_rs485_rx : assert property (@(posedge clk)
    rs485_rx == (!rs485_ctrl.ren && rs485_model_tx))
    else begin
      errors++;
      $display("Mismatch rs485_rx_o: got %h, ren %h tx %h", $sampled(rs485_rx),
               $sampled(rs485_ctrl.ren), $sampled(rs485_model_tx));
    end

  a_rs485_line : assert property (@(posedge clk)
    rs485_model_rx == pulled_up_level(rs485_ctrl.di, rs485_ctrl.de))
    else begin
      errors++;
      $display("Mismatch rs485_model_rx_o: got %h, di %h de %h", $sampled(rs485_model_rx),
               $sampled(rs485_ctrl.di), $sampled(rs485_ctrl.de));
    end

  a_loop : assert property (@(posedge clk) disable iff (!rst_n) loop_out == loop_prev)
    else begin
      errors++;
      $display("Mismatch loop_o: got %h expected %h", $sampled(loop_out), $sampled(loop_prev));
    end

  a_req_reset : assert property (@(posedge clk) $rose(rst_n) |-> !report_req)
    else begin
      errors++;
      $display("Report request was high right after reset");
    end

  a_seen : assert property (@(posedge clk) disable iff (!rst_n) faults_seen == seen_m)
    else begin
      errors++;
      $display("Mismatch faults_seen_o: got %h expected %h", $sampled(faults_seen),
               $sampled(seen_m));
    end

  // A new report carries the lowest fault that was waiting.
  a_order : assert property (@(posedge clk) disable iff (!rst_n)
    report_req && !req_prev |-> report_code == lowest_set(pending_prev))
    else begin
      errors++;
      $display("Mismatch report_code_o: got %h expected %h", $sampled(report_code),
               lowest_set($sampled(pending_prev)));
    end

  a_code_hold : assert property (@(posedge clk) disable iff (!rst_n)
    report_req && req_prev |-> report_code == code_prev)
    else begin
      errors++;
      $display("Mismatch report_code_o: got %h expected %h", $sampled(report_code),
               $sampled(code_prev));
    end

  a_req_hold : assert property (@(posedge clk) disable iff (!rst_n)
    report_req && !report_ack |=> report_req)
    else begin
      errors++;
      $display("Report request dropped before it was acknowledged");
    end

  // Ack responder, slow in the second half of the run.
  initial begin
    int unsigned delay;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      if (report_req && !report_ack) begin
        delay = $unsigned($random(seed)) % (ack_slow ? 13 : 2);
        repeat (delay) @(negedge clk);
        report_ack = 1'b1;
        while (report_req) @(negedge clk);
        delay = $unsigned($random(seed)) % (ack_slow ? 5 : 2);
        repeat (delay) @(negedge clk);
        report_ack = 1'b0;
      end
    end
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: fault reports did not finish in time");
    $display("Errors: %0d, reports: %0d", errors, reports);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed           = 32'h2968;
    errors         = 0;
    ack_slow       = 1'b0;
    i2c_ctrl       = '0;
    i2c_dev        = '1;
    spi_ctrl       = '0;
    spi_cipo       = 1'b0;
    rs485_ctrl     = '0;
    rs485_model_tx = 1'b1;
    loop_in        = '0;
    fault          = '0;
    report_ack     = 1'b0;
    @(posedge rst_n);
    for (int cyc = 0; cyc < NumCycles; cyc++) begin
      @(negedge clk);
      drive_pads();
      fault    = fault_pattern(cyc);
      ack_slow = (cyc >= SlowAckFrom);
    end
    // Let every waiting fault go out.
    while (report_req || report_ack || (reported_m != seen_m)) @(negedge clk);
    repeat (3) @(negedge clk);
    a_all_reported : assert (seen_m == '1 && reported_m == seen_m && reports == NumFaults)
      else begin
        errors++;
        $display("Mismatch reported kinds: got %h expected %h", reported_m, {NumFaults{1'b1}});
      end
    $display("Errors: %0d, reports: %0d", errors, reports);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
board_pkg.sv
pad_ring.sv
fault_reporter.sv
sim_board_top.sv
tb_clkgen.sv
tb_sim_board.sv

// ==== Bender.yml ====
package:
  name: sim_board

sources:
  - board_pkg.sv
  - pad_ring.sv
  - fault_reporter.sv
  - sim_board_top.sv
  - target: simulation
    files:
      - tb_clkgen.sv
      - tb_sim_board.sv
